//--- hw/lsu_params.svh
// LSU sizing parameters

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Data RAM depth in 32-bit words
`define LSU_RAM_WORDS 256
// Word index width, log2 of the depth
`define LSU_RAM_AW 8

// Request queue entries
`define LSU_QUEUE_DEPTH 4
// Destination register index width
`define LSU_RD_W 5

`endif

//--- hw/lsu_pkg.sv
// LSU shared types

`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

    // Access width of one load or store
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // One queued load/store request
    typedef struct packed {
        logic [31:0]            addr;
        logic [31:0]            wdata;
        logic [`LSU_RD_W-1:0]   rd;
        logic                   is_store;
        mem_size_e              size;
        logic                   uns;
    } lsu_req_t;

endpackage

`default_nettype wire

//--- hw/mem_bus_if.sv
// Word-aligned memory bus

`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

interface mem_bus_if;

    // Request side, held until ack
    logic [`LSU_RAM_AW-1:0] addr;
    logic [31:0]            wdata;
    logic [3:0]             wmask;
    logic                   we;
    logic                   req;

    // Response side, rdata valid with ack
    logic                   ack;
    logic [31:0]            rdata;

    modport master (output addr, wdata, wmask, we, req, input ack, rdata);
    modport slave  (input addr, wdata, wmask, we, req, output ack, rdata);

endinterface

`default_nettype wire

//--- hw/lsu_request_queue.sv
// LSU request queue

`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_request_queue (
    input  logic                    clk,
    input  logic                    rstz,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic [31:0]             req_addr,
    input  logic [31:0]             req_wdata,
    input  logic [`LSU_RD_W-1:0]    req_rd,
    input  logic                    req_store,
    input  lsu_pkg::mem_size_e      req_size,
    input  logic                    req_uns,
    output logic                    q_valid,
    output lsu_pkg::lsu_req_t       q_req,
    input  logic                    q_ready
);

    localparam int unsigned QD = `LSU_QUEUE_DEPTH;
    localparam int unsigned PW = (QD > 1) ? $clog2(QD) : 1;
    localparam int unsigned CW = $clog2(QD + 1);
    localparam logic [PW-1:0] LAST = PW'(QD - 1);
    localparam logic [CW-1:0] FULL = CW'(QD);

    lsu_pkg::lsu_req_t entries [QD];
    logic [PW-1:0] wptr, rptr;
    logic [CW-1:0] count;
    logic push, pop;

    assign req_ready = (count != FULL);
    assign q_valid = (count != '0);
    // Head entry shows directly
    assign q_req = entries[rptr];

    assign push = req_valid && req_ready;
    assign pop = q_valid && q_ready;

    // Pointers wrap at depth and count tracks both ends
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            wptr <= '0;
            rptr <= '0;
            count <= '0;
        end else begin
            if (push) wptr <= (wptr == LAST) ? '0 : wptr + 1'b1;
            if (pop) rptr <= (rptr == LAST) ? '0 : rptr + 1'b1;
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    // Field packing at intake
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wptr] <= '{addr: req_addr, wdata: req_wdata, rd: req_rd,
                               is_store: req_store, size: req_size, uns: req_uns};
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rstz) count <= FULL);
    // Empty and full both leave the pointers level
    a_ptr_level: assert property (@(posedge clk) disable iff (!rstz)
        (count == '0 || count == FULL) |-> wptr == rptr);

endmodule

`default_nettype wire

//--- hw/lsu_core.sv
// LSU sequencer
// Split unaligned access, rotation and extension

`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_core (
    input  logic                    clk,
    input  logic                    rstz,
    input  logic                    q_valid,
    input  lsu_pkg::lsu_req_t       q_req,
    output logic                    q_ready,
    mem_bus_if.master               mem,
    output logic                    resp_valid,
    output logic [31:0]             resp_data,
    output logic [`LSU_RD_W-1:0]    resp_rd,
    output logic                    done,
    output logic                    done_misaligned
);

    typedef enum logic [2:0] {
        IDLE, READ1, READ2, LOAD, WRITE1, WRITE2, STORE
    } state_e;

    state_e state, next_state;
    logic start;

    // Decode of the head request
    logic [1:0] in_off;
    logic [3:0] in_base_mask;
    logic [7:0] in_mask;
    logic in_misaligned;

    // Latched operation context
    logic [1:0] off_r;
    lsu_pkg::mem_size_e size_r;
    logic uns_r;
    logic wb_ok_r;
    logic split_r;
    logic [3:0] upper_mask_r;

    // Read bytes, newest and previous
    logic [3:0][7:0] cur_b, prev_b, word_b;

    // Byte rotations on a doubled word
    function automatic logic [31:0] rotr_bytes(input logic [31:0] w, input logic [1:0] k);
        logic [63:0] dbl;
        dbl = {w, w} >> {k, 3'b000};
        return dbl[31:0];
    endfunction

    function automatic logic [31:0] rotl_bytes(input logic [31:0] w, input logic [1:0] k);
        logic [63:0] dbl;
        dbl = {w, w} << {k, 3'b000};
        return dbl[63:32];
    endfunction

    // ==================================================
    // Sequencer
    // ==================================================

    assign q_ready = (state == IDLE);
    assign start = q_valid && q_ready;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) state <= IDLE;
        else state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: if (start) next_state = q_req.is_store ? WRITE1 : READ1;
            READ1: if (mem.ack) next_state = split_r ? READ2 : LOAD;
            READ2: if (mem.ack) next_state = LOAD;
            WRITE1: if (mem.ack) next_state = split_r ? WRITE2 : STORE;
            WRITE2: if (mem.ack) next_state = STORE;
            default: next_state = IDLE;
        endcase
    end

    // Byte offset within the word
    assign in_off = q_req.addr[1:0];

    // Half at offset 3 or word off zero spills into the next word
    assign in_misaligned = (q_req.size == lsu_pkg::SIZE_HALF && in_off == 2'd3)
                        || (q_req.size == lsu_pkg::SIZE_WORD && in_off != 2'd0);

    always_comb begin
        case (q_req.size)
            lsu_pkg::SIZE_BYTE: in_base_mask = 4'b0001;
            lsu_pkg::SIZE_HALF: in_base_mask = 4'b0011;
            default: in_base_mask = 4'b1111;
        endcase
    end

    // Low nibble for the first word, high nibble for the second
    assign in_mask = {4'b0000, in_base_mask} << in_off;

    always_ff @(posedge clk) begin
        if (start) begin
            off_r <= in_off;
            size_r <= q_req.size;
            uns_r <= q_req.uns;
            wb_ok_r <= (q_req.rd != '0);
            split_r <= in_misaligned;
            upper_mask_r <= in_mask[7:4];
            resp_rd <= q_req.rd;
        end
    end

    // ==================================================
    // Memory bus
    // ==================================================

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            mem.req <= 1'b0;
            mem.we <= 1'b0;
        end else if (start) begin
            mem.req <= 1'b1;
            mem.we <= q_req.is_store;
        end else if (mem.ack) begin
            // Second half keeps req up
            if (!((state == READ1 || state == WRITE1) && split_r)) begin
                mem.req <= 1'b0;
                mem.we <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mem.addr <= q_req.addr[`LSU_RAM_AW+1:2];
            mem.wdata <= rotl_bytes(q_req.wdata, in_off);
            mem.wmask <= in_mask[3:0];
        end else if (mem.ack && (state == READ1 || state == WRITE1) && split_r) begin
            // Next word, wraps at top of RAM
            mem.addr <= mem.addr + 1'b1;
            mem.wmask <= upper_mask_r;
        end
    end

    // ==================================================
    // Load assembly
    // ==================================================

    always_ff @(posedge clk) begin
        if (mem.ack) begin
            cur_b <= rotr_bytes(mem.rdata, off_r);
            prev_b <= cur_b;
        end
    end

    // Low bytes of a split load come from the first word
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            word_b[i] = (split_r && (i < 4 - int'(off_r))) ? prev_b[i] : cur_b[i];
        end
    end

    always_comb begin
        case (size_r)
            lsu_pkg::SIZE_BYTE:
                resp_data = uns_r ? {24'b0, word_b[0]} : {{24{word_b[0][7]}}, word_b[0]};
            lsu_pkg::SIZE_HALF:
                resp_data = uns_r ? {16'b0, word_b[1:0]} : {{16{word_b[1][7]}}, word_b[1:0]};
            default:
                resp_data = word_b;
        endcase
    end

    assign done = (state == LOAD) || (state == STORE);
    assign done_misaligned = done && split_r;
    // No register write for x0
    assign resp_valid = (state == LOAD) && wb_ok_r;

    a_bus_hold: assert property (@(posedge clk) disable iff (!rstz)
        mem.req && !mem.ack |=> mem.req && $stable(mem.addr));

endmodule

`default_nettype wire

//--- hw/data_ram.sv
// Byte-masked data RAM

`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module data_ram (
    input  logic        clk,
    input  logic        rstz,
    mem_bus_if.slave    mem
);

    localparam int unsigned WORDS = `LSU_RAM_WORDS;

    logic [3:0][7:0] ram [WORDS];
    logic access;

    // Contents start cleared
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            ram[i] = '0;
        end
    end

    // New request only when no ack is pending
    assign access = mem.req && !mem.ack;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) mem.ack <= 1'b0;
        else mem.ack <= access;
    end

    // Index width equals log2 depth, so the word index wraps
    always_ff @(posedge clk) begin
        if (access) begin
            if (mem.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem.wmask[b]) ram[mem.addr][b] <= mem.wdata[8*b +: 8];
                end
            end
            mem.rdata <= ram[mem.addr];
        end
    end

    a_wmask_set: assert property (@(posedge clk) disable iff (!rstz)
        mem.req && mem.we |-> mem.wmask != 4'b0000);

endmodule

`default_nettype wire

//--- hw/lsu_top.sv
// Load/store subsystem top

`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_top (
    input  logic                    clk,
    input  logic                    rstz,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic [31:0]             req_addr,
    input  logic [31:0]             req_wdata,
    input  logic [`LSU_RD_W-1:0]    req_rd,
    input  logic                    req_store,
    input  lsu_pkg::mem_size_e      req_size,
    input  logic                    req_uns,
    output logic                    resp_valid,
    output logic [31:0]             resp_data,
    output logic [`LSU_RD_W-1:0]    resp_rd,
    output logic                    done,
    output logic                    done_misaligned
);

    // Queue head to sequencer
    logic q_valid;
    logic q_ready;
    lsu_pkg::lsu_req_t q_req;

    mem_bus_if mem_bus ();

    lsu_request_queue u_queue (
        .clk(clk), .rstz(rstz),
        .req_valid(req_valid), .req_ready(req_ready),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_rd(req_rd),
        .req_store(req_store), .req_size(req_size), .req_uns(req_uns),
        .q_valid(q_valid), .q_req(q_req), .q_ready(q_ready)
    );

    lsu_core u_core (
        .clk(clk), .rstz(rstz),
        .q_valid(q_valid), .q_req(q_req), .q_ready(q_ready),
        .mem(mem_bus.master),
        .resp_valid(resp_valid), .resp_data(resp_data), .resp_rd(resp_rd),
        .done(done), .done_misaligned(done_misaligned)
    );

    data_ram u_ram (.clk(clk), .rstz(rstz), .mem(mem_bus.slave));

endmodule

`default_nettype wire

//--- tests/lsu_tb.sv
// LSU subsystem testbench

`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_tb;

    localparam int AW = `LSU_RAM_AW;
    localparam int RD_W = `LSU_RD_W;
    localparam int RAM_BYTES = 4 * `LSU_RAM_WORDS;
    localparam logic [31:0] BYTE_MASK = 32'(RAM_BYTES - 1);
    localparam logic [AW-1:0] WIN_BASE = AW'(192);
    // Operations issued by each test in turn
    localparam int TOTAL_OPS = 16 + 72 + 48 + 16 + 64 + 17;
    localparam int CYCLE_LIMIT = 20 * TOTAL_OPS + 100;

    typedef struct packed {
        logic                resp;
        logic                mis;
        logic [31:0]         data;
        logic [RD_W-1:0]     rd;
    } exp_t;

    logic clk = 1'b0;
    logic rstz;
    logic req_valid, req_ready, req_store, req_uns;
    logic [31:0] req_addr, req_wdata;
    logic [RD_W-1:0] req_rd;
    lsu_pkg::mem_size_e req_size;
    logic resp_valid, done, done_misaligned;
    logic [31:0] resp_data;
    logic [RD_W-1:0] resp_rd;

    // Reference byte memory and in-order expectations
    logic [7:0] model_mem [RAM_BYTES];
    exp_t exp_q[$];
    exp_t mon_e;

    logic [31:0] lfsr_state = 32'd92152;
    int errors = 0;
    int test_err_base = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int accepted = 0;
    int done_count = 0;
    int cycles = 0;
    logic saw_full = 1'b0;

    always #5 clk = ~clk;

    lsu_top uut (
        .clk(clk), .rstz(rstz),
        .req_valid(req_valid), .req_ready(req_ready),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_rd(req_rd),
        .req_store(req_store), .req_size(req_size), .req_uns(req_uns),
        .resp_valid(resp_valid), .resp_data(resp_data), .resp_rd(resp_rd),
        .done(done), .done_misaligned(done_misaligned)
    );

    // ==================================================
    // Random source and helpers
    // ==================================================

    // Fibonacci LFSR stepped once per bit with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [RD_W-1:0] nonzero_rd();
        logic [RD_W-1:0] r;
        r = RD_W'(rand_bits(RD_W));
        return (r == '0) ? RD_W'(1) : r;
    endfunction

    function automatic lsu_pkg::mem_size_e rand_size();
        logic [31:0] s;
        s = rand_bits(2);
        if (s == 0) return lsu_pkg::SIZE_BYTE;
        if (s == 1) return lsu_pkg::SIZE_HALF;
        return lsu_pkg::SIZE_WORD;
    endfunction

    function automatic logic [31:0] word_addr(input logic [AW-1:0] w);
        return {{(30 - AW){1'b0}}, w, 2'b00};
    endfunction

    // Apply a store or predict a load at acceptance
    task automatic model_accept(input logic [31:0] addr, input logic [31:0] wdata,
                                input logic [RD_W-1:0] rd, input logic store,
                                input lsu_pkg::mem_size_e size, input logic uns);
        int n;
        int a;
        logic [31:0] v;
        exp_t e;
        n = (size == lsu_pkg::SIZE_BYTE) ? 1 : (size == lsu_pkg::SIZE_HALF) ? 2 : 4;
        a = int'(addr & BYTE_MASK);
        v = '0;
        for (int i = 0; i < n; i++) begin
            if (store) model_mem[(a + i) % RAM_BYTES] = wdata[8*i +: 8];
            else v[8*i +: 8] = model_mem[(a + i) % RAM_BYTES];
        end
        if (!uns && size == lsu_pkg::SIZE_BYTE) v = {{24{v[7]}}, v[7:0]};
        if (!uns && size == lsu_pkg::SIZE_HALF) v = {{16{v[15]}}, v[15:0]};
        e.resp = !store && (rd != '0);
        // Spills into the next word
        e.mis = (int'(addr[1:0]) + n) > 4;
        e.data = v;
        e.rd = rd;
        exp_q.push_back(e);
        accepted++;
    endtask

    // Offer one request 1 ns after a rising edge
    task automatic issue(input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [RD_W-1:0] rd, input logic store,
                         input lsu_pkg::mem_size_e size, input logic uns);
        req_valid = 1'b1;
        req_addr = addr;
        req_wdata = wdata;
        req_rd = rd;
        req_store = store;
        req_size = size;
        req_uns = uns;
        @(negedge clk);
        while (!req_ready) begin
            saw_full = 1'b1;
            @(negedge clk);
        end
        model_accept(addr, wdata, rd, store, size, uns);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name);
        drain();
        if (errors == test_err_base) begin
            $display("PASS  %s", name);
            tests_passed++;
        end else begin
            $display("FAIL  %s (%0d errors)", name, errors - test_err_base);
            tests_failed++;
        end
        test_err_base = errors;
    endtask

    // ==================================================
    // Result monitor and watchdog
    // ==================================================

    always @(negedge clk) begin
        if (rstz) begin
            if (done) begin
                done_count++;
                if (exp_q.size() == 0) begin
                    $display("ERROR at %0t: done pulsed with no operation outstanding", $time);
                    errors++;
                end else begin
                    mon_e = exp_q.pop_front();
                    if (done_misaligned !== mon_e.mis) begin
                        $display("MISMATCH at %0t: done_misaligned %b, expected %b",
                                 $time, done_misaligned, mon_e.mis);
                        errors++;
                    end
                    if (resp_valid !== mon_e.resp) begin
                        $display("MISMATCH at %0t: resp_valid %b, expected %b",
                                 $time, resp_valid, mon_e.resp);
                        errors++;
                    end else if (mon_e.resp && (resp_data !== mon_e.data
                                                || resp_rd !== mon_e.rd)) begin
                        $display("MISMATCH at %0t: load data %h rd %0d, expected %h rd %0d",
                                 $time, resp_data, resp_rd, mon_e.data, mon_e.rd);
                        errors++;
                    end
                end
            end else if (resp_valid) begin
                $display("ERROR at %0t: resp_valid pulsed without done", $time);
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        logic [AW-1:0] widx;
        logic [AW-1:0] nxt;
        logic [31:0] addr;
        logic [31:0] hi;
        logic [31:0] t;
        logic [1:0] off;
        logic [RD_W-1:0] rd;
        lsu_pkg::mem_size_e size;

        rstz = 1'b0;
        req_valid = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        req_rd = '0;
        req_store = 1'b0;
        req_size = lsu_pkg::SIZE_BYTE;
        req_uns = 1'b0;
        for (int i = 0; i < RAM_BYTES; i++) model_mem[i] = 8'h00;
        repeat (3) @(posedge clk);
        #1;
        rstz = 1'b1;
        @(posedge clk);
        #1;

        // Aligned word round trip
        for (int i = 0; i < 8; i++) begin
            widx = AW'(rand_bits(AW));
            rd = nonzero_rd();
            issue(word_addr(widx), rand_bits(32), rd, 1'b1, lsu_pkg::SIZE_WORD, 1'b0);
            issue(word_addr(widx), '0, rd, 1'b0, lsu_pkg::SIZE_WORD, 1'b0);
        end
        report_test("aligned word store and load");

        // Byte and half at each offset with both extensions
        for (int r = 0; r < 4; r++) begin
            widx = AW'(rand_bits(AW));
            nxt = widx + 1'b1;
            issue(word_addr(widx), rand_bits(32), nonzero_rd(), 1'b1, lsu_pkg::SIZE_WORD, 1'b0);
            issue(word_addr(nxt), rand_bits(32), nonzero_rd(), 1'b1, lsu_pkg::SIZE_WORD, 1'b0);
            for (int o = 0; o < 4; o++) begin
                for (int u = 0; u < 2; u++) begin
                    addr = word_addr(widx) | 32'(o);
                    issue(addr, '0, nonzero_rd(), 1'b0, lsu_pkg::SIZE_BYTE, u[0]);
                    issue(addr, '0, nonzero_rd(), 1'b0, lsu_pkg::SIZE_HALF, u[0]);
                end
            end
        end
        report_test("byte and half loads at all offsets");

        // Split accesses with every fourth at the top word
        for (int i = 0; i < 12; i++) begin
            widx = (i % 4 == 0) ? '1 : AW'(rand_bits(AW));
            nxt = widx + 1'b1;
            t = rand_bits(3);
            if (t[0]) begin
                size = lsu_pkg::SIZE_HALF;
                off = 2'd3;
            end else begin
                size = lsu_pkg::SIZE_WORD;
                off = (t[2:1] == 2'd0) ? 2'd1 : t[2:1];
            end
            hi = rand_bits(32);
            addr = {hi[29-AW:0], widx, off};
            issue(addr, rand_bits(32), nonzero_rd(), 1'b1, size, 1'b0);
            // Neighbouring bytes must be untouched
            issue(word_addr(widx), '0, nonzero_rd(), 1'b0, lsu_pkg::SIZE_WORD, 1'b0);
            issue(word_addr(nxt), '0, nonzero_rd(), 1'b0, lsu_pkg::SIZE_WORD, 1'b0);
            issue(addr, '0, nonzero_rd(), 1'b0, size, t[2]);
        end
        report_test("misaligned split accesses");

        // No writeback for x0 or for stores
        for (int i = 0; i < 8; i++) begin
            widx = AW'(rand_bits(AW));
            issue(word_addr(widx), rand_bits(32), nonzero_rd(), 1'b1, rand_size(), 1'b0);
            issue(word_addr(widx), '0, '0, 1'b0, rand_size(), 1'b0);
        end
        report_test("rd 0 loads and store responses");

        // Burst in a 16-word window to fill the queue
        saw_full = 1'b0;
        for (int i = 0; i < 64; i++) begin
            widx = WIN_BASE + AW'(rand_bits(4));
            off = 2'(rand_bits(2));
            t = rand_bits(2);
            issue(word_addr(widx) | 32'(off), rand_bits(32), RD_W'(rand_bits(RD_W)), t[0],
                  rand_size(), t[1]);
        end
        if (!saw_full) begin
            $display("ERROR at %0t: req_ready never dropped during the burst", $time);
            errors++;
        end
        // Window plus the word a split may spill into
        for (int w = 0; w < 17; w++) begin
            issue(word_addr(WIN_BASE + AW'(w)), '0, nonzero_rd(), 1'b0, lsu_pkg::SIZE_WORD, 1'b0);
        end
        drain();
        if (accepted != done_count) begin
            $display("ERROR at %0t: %0d requests accepted but %0d done pulses", $time,
                     accepted, done_count);
            errors++;
        end
        report_test("back-pressure burst and read-back");

        $display("summary: %0d passed, %0d failed, %0d errors, %0d operations",
                 tests_passed, tests_failed, errors, done_count);
        if (tests_failed == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+hw
hw/lsu_pkg.sv
hw/mem_bus_if.sv
hw/lsu_request_queue.sv
hw/lsu_core.sv
hw/data_ram.sv
hw/lsu_top.sv
tests/lsu_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build lsu_tb with Verilator, run it, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module lsu_tb -o Vlsu_tb
	./obj_dir/Vlsu_tb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi
	@grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
